// File: design/alu.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu (
    input  logic [`EX_DATA_W-1:0]  i_data_a,
    input  logic [`EX_DATA_W-1:0]  i_data_b,
    input  ex_pkg::alu_func_e      i_alu_func,
    output logic [`EX_DATA_W-1:0]  o_result,
    output logic                   o_zero
);

    logic [4:0] shamt;

    // Shift amount from the low bits of B
    assign shamt = i_data_b[4:0];

    always_comb begin
        case (i_alu_func)
            ex_pkg::FUNC_ADD:  o_result = i_data_a + i_data_b;
            ex_pkg::FUNC_SUB:  o_result = i_data_a - i_data_b;
            ex_pkg::FUNC_AND:  o_result = i_data_a & i_data_b;
            ex_pkg::FUNC_OR:   o_result = i_data_a | i_data_b;
            ex_pkg::FUNC_XOR:  o_result = i_data_a ^ i_data_b;
            ex_pkg::FUNC_NOR:  o_result = ~(i_data_a | i_data_b);
            ex_pkg::FUNC_SLT: begin
                o_result = {{(`EX_DATA_W-1){1'b0}}, $signed(i_data_a) < $signed(i_data_b)};
            end
            ex_pkg::FUNC_SLTU: begin
                o_result = {{(`EX_DATA_W-1){1'b0}}, i_data_a < i_data_b};
            end
            ex_pkg::FUNC_SLL:  o_result = i_data_a << shamt;
            ex_pkg::FUNC_SRL:  o_result = i_data_a >> shamt;
            // Arithmetic shift keeps the sign of A
            ex_pkg::FUNC_SRA:  o_result = $unsigned($signed(i_data_a) >>> shamt);
            ex_pkg::FUNC_LUI:  o_result = i_data_b << 16;
            default:           o_result = i_data_a + i_data_b;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// File: design/alu_control.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_control (
    input  ex_pkg::alu_class_e      i_alu_class,
    input  logic [`EX_FUNCT_W-1:0]  i_funct,
    output ex_pkg::alu_func_e       o_alu_func
);

    always_comb begin
        case (i_alu_class)
            ex_pkg::CLASS_R_TYPE: begin
                // MIPS function codes, unsigned forms share the signed adder
                case (i_funct)
                    6'h20, 6'h21: o_alu_func = ex_pkg::FUNC_ADD;
                    6'h22, 6'h23: o_alu_func = ex_pkg::FUNC_SUB;
                    6'h24:        o_alu_func = ex_pkg::FUNC_AND;
                    6'h25:        o_alu_func = ex_pkg::FUNC_OR;
                    6'h26:        o_alu_func = ex_pkg::FUNC_XOR;
                    6'h27:        o_alu_func = ex_pkg::FUNC_NOR;
                    6'h2a:        o_alu_func = ex_pkg::FUNC_SLT;
                    6'h2b:        o_alu_func = ex_pkg::FUNC_SLTU;
                    6'h00:        o_alu_func = ex_pkg::FUNC_SLL;
                    6'h02:        o_alu_func = ex_pkg::FUNC_SRL;
                    6'h03:        o_alu_func = ex_pkg::FUNC_SRA;
                    default:      o_alu_func = ex_pkg::FUNC_ADD;
                endcase
            end
            ex_pkg::CLASS_SUB:   o_alu_func = ex_pkg::FUNC_SUB;
            ex_pkg::CLASS_AND_I: o_alu_func = ex_pkg::FUNC_AND;
            ex_pkg::CLASS_OR_I:  o_alu_func = ex_pkg::FUNC_OR;
            ex_pkg::CLASS_XOR_I: o_alu_func = ex_pkg::FUNC_XOR;
            ex_pkg::CLASS_SLT_I: o_alu_func = ex_pkg::FUNC_SLT;
            ex_pkg::CLASS_LUI:   o_alu_func = ex_pkg::FUNC_LUI;
            default:             o_alu_func = ex_pkg::FUNC_ADD;
        endcase
    end

endmodule

// File: design/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    // ALU class coming out of the decoder
    typedef enum logic [2:0] {
        CLASS_R_TYPE = 3'd0,
        CLASS_ADD    = 3'd1,
        CLASS_SUB    = 3'd2,
        CLASS_AND_I  = 3'd3,
        CLASS_OR_I   = 3'd4,
        CLASS_XOR_I  = 3'd5,
        CLASS_SLT_I  = 3'd6,
        CLASS_LUI    = 3'd7
    } alu_class_e;

    // Operation performed by the ALU
    typedef enum logic [3:0] {
        FUNC_ADD  = 4'd0,
        FUNC_SUB  = 4'd1,
        FUNC_AND  = 4'd2,
        FUNC_OR   = 4'd3,
        FUNC_XOR  = 4'd4,
        FUNC_NOR  = 4'd5,
        FUNC_SLT  = 4'd6,
        FUNC_SLTU = 4'd7,
        FUNC_SLL  = 4'd8,
        FUNC_SRL  = 4'd9,
        FUNC_SRA  = 4'd10,
        FUNC_LUI  = 4'd11
    } alu_func_e;

    // Operand source chosen by forwarding
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // --------------------------------------------------
    // Stage payloads
    // --------------------------------------------------
    typedef struct packed {
        logic                     valid;
        alu_class_e               alu_class;
        logic                     alu_src;
        logic                     reg_dst;
        logic                     branch;
        logic [1:0]               jump;
        logic                     mem_read;
        logic                     mem_write;
        logic                     mem_to_reg;
        logic                     reg_write;
        logic                     halt;
        logic [`EX_DATA_W-1:0]    pc_4;
        logic [`EX_DATA_W-1:0]    read_data_1;
        logic [`EX_DATA_W-1:0]    read_data_2;
        logic [`EX_DATA_W-1:0]    extended;
        logic [`EX_FUNCT_W-1:0]   funct;
        logic [`EX_REG_W-1:0]     rs;
        logic [`EX_REG_W-1:0]     rt;
        logic [`EX_REG_W-1:0]     rd;
        logic [`EX_REG_W-1:0]     sa;
    } id_ex_t;

    typedef struct packed {
        logic                     valid;
        logic                     branch;
        logic [1:0]               jump;
        logic                     mem_read;
        logic                     mem_write;
        logic                     mem_to_reg;
        logic                     reg_write;
        logic                     halt;
        logic [`EX_DATA_W-1:0]    pc_4;
        logic [`EX_DATA_W-1:0]    pc_branch;
        logic [`EX_DATA_W-1:0]    alu_result;
        logic [`EX_DATA_W-1:0]    store_data;
        logic [`EX_FUNCT_W-1:0]   funct;
        logic [`EX_REG_W-1:0]     dest_reg;
        logic                     zero;
    } ex_mem_t;

    // Result of a later stage offered for forwarding
    typedef struct packed {
        logic                     reg_write;
        logic [`EX_REG_W-1:0]     dest_reg;
        logic [`EX_DATA_W-1:0]    data;
    } fwd_src_t;

endpackage

// File: design/ex_unit_top.sv
`timescale 1ns/1ps

module ex_unit_top (
    input  logic              i_clock,
    input  logic              i_reset,
    input  ex_pkg::id_ex_t    i_id_ex,
    input  ex_pkg::fwd_src_t  i_mem_fwd,
    input  ex_pkg::fwd_src_t  i_wb_fwd,
    input  logic              i_exec_mode,
    input  logic              i_step,
    input  logic              i_flush,
    output ex_pkg::ex_mem_t   o_ex_mem,
    output logic              o_advance,
    output logic              o_halted
);

    ex_pkg::id_ex_t    id_ex_q;
    ex_pkg::ex_mem_t   ex_mem_d;
    ex_pkg::ex_mem_t   ex_mem_next;
    ex_pkg::fwd_sel_e  sel_a;
    ex_pkg::fwd_sel_e  sel_b;
    logic              capture;
    logic              halt_seen;

    // --------------------------------------------------
    // ID/EX register
    // --------------------------------------------------
    stage_register #(
        .payload_t  (ex_pkg::id_ex_t)
    ) u_id_ex_reg (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_enable   (o_advance),
        .i_data     (i_id_ex),
        .o_data     (id_ex_q)
    );

    forwarding_unit u_forwarding_unit (
        .i_rs       (id_ex_q.rs),
        .i_rt       (id_ex_q.rt),
        .i_mem_fwd  (i_mem_fwd),
        .i_wb_fwd   (i_wb_fwd),
        .o_sel_a    (sel_a),
        .o_sel_b    (sel_b)
    );

    execute_stage u_execute_stage (
        .i_id_ex     (id_ex_q),
        .i_sel_a     (sel_a),
        .i_sel_b     (sel_b),
        .i_mem_data  (i_mem_fwd.data),
        .i_wb_data   (i_wb_fwd.data),
        .o_ex_mem    (ex_mem_d)
    );

    // Flushed or held instructions leave EX as bubbles
    assign capture     = o_advance && id_ex_q.valid && !i_flush;
    assign ex_mem_next = capture ? ex_mem_d : '0;

    // --------------------------------------------------
    // EX/MEM register, loads every cycle
    // --------------------------------------------------
    stage_register #(
        .payload_t  (ex_pkg::ex_mem_t)
    ) u_ex_mem_reg (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_enable   (1'b1),
        .i_data     (ex_mem_next),
        .o_data     (o_ex_mem)
    );

    assign halt_seen = o_ex_mem.valid && o_ex_mem.halt;

    step_controller u_step_controller (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_exec_mode  (i_exec_mode),
        .i_step       (i_step),
        .i_halt_seen  (halt_seen),
        .o_advance    (o_advance),
        .o_halted     (o_halted)
    );

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module execute_stage (
    input  ex_pkg::id_ex_t         i_id_ex,
    input  ex_pkg::fwd_sel_e       i_sel_a,
    input  ex_pkg::fwd_sel_e       i_sel_b,
    input  logic [`EX_DATA_W-1:0]  i_mem_data,
    input  logic [`EX_DATA_W-1:0]  i_wb_data,
    output ex_pkg::ex_mem_t        o_ex_mem
);

    ex_pkg::alu_func_e      alu_func;
    logic                   is_shift;
    logic [`EX_DATA_W-1:0]  fwd_a;
    logic [`EX_DATA_W-1:0]  fwd_b;
    logic [`EX_DATA_W-1:0]  data_a;
    logic [`EX_DATA_W-1:0]  data_b;
    logic [`EX_DATA_W-1:0]  alu_result;
    logic                   zero;

    function automatic logic [`EX_DATA_W-1:0] operand_mux(
        ex_pkg::fwd_sel_e sel,
        logic [`EX_DATA_W-1:0] reg_data
    );
        case (sel)
            ex_pkg::FWD_MEM: return i_mem_data;
            ex_pkg::FWD_WB:  return i_wb_data;
            default:         return reg_data;
        endcase
    endfunction

    // --------------------------------------------------
    // Operand selection
    // --------------------------------------------------
    assign fwd_a = operand_mux(i_sel_a, i_id_ex.read_data_1);
    assign fwd_b = operand_mux(i_sel_b, i_id_ex.read_data_2);

    assign is_shift = (alu_func == ex_pkg::FUNC_SLL) ||
                      (alu_func == ex_pkg::FUNC_SRL) ||
                      (alu_func == ex_pkg::FUNC_SRA);

    // Shifts work on rt by the shamt field
    assign data_a = is_shift ? fwd_b : fwd_a;

    always_comb begin
        if (i_id_ex.alu_src) begin
            data_b = i_id_ex.extended;
        end else if (is_shift) begin
            data_b = {{(`EX_DATA_W-`EX_REG_W){1'b0}}, i_id_ex.sa};
        end else begin
            data_b = fwd_b;
        end
    end

    alu_control u_alu_control (
        .i_alu_class  (i_id_ex.alu_class),
        .i_funct      (i_id_ex.funct),
        .o_alu_func   (alu_func)
    );

    alu u_alu (
        .i_data_a     (data_a),
        .i_data_b     (data_b),
        .i_alu_func   (alu_func),
        .o_result     (alu_result),
        .o_zero       (zero)
    );

    // --------------------------------------------------
    // EX/MEM payload
    // --------------------------------------------------
    always_comb begin
        o_ex_mem            = '0;
        o_ex_mem.valid      = i_id_ex.valid;
        o_ex_mem.branch     = i_id_ex.branch;
        o_ex_mem.jump       = i_id_ex.jump;
        o_ex_mem.mem_read   = i_id_ex.mem_read;
        o_ex_mem.mem_write  = i_id_ex.mem_write;
        o_ex_mem.mem_to_reg = i_id_ex.mem_to_reg;
        o_ex_mem.reg_write  = i_id_ex.reg_write;
        o_ex_mem.halt       = i_id_ex.halt;
        o_ex_mem.pc_4       = i_id_ex.pc_4;
        // Word offset turned into a byte offset
        o_ex_mem.pc_branch  = i_id_ex.pc_4 + (i_id_ex.extended << 2);
        o_ex_mem.alu_result = alu_result;
        o_ex_mem.store_data = fwd_b;
        o_ex_mem.funct      = i_id_ex.funct;
        o_ex_mem.dest_reg   = i_id_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;
        o_ex_mem.zero       = zero;
    end

endmodule

// File: design/forwarding_unit.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module forwarding_unit (
    input  logic [`EX_REG_W-1:0]  i_rs,
    input  logic [`EX_REG_W-1:0]  i_rt,
    input  ex_pkg::fwd_src_t      i_mem_fwd,
    input  ex_pkg::fwd_src_t      i_wb_fwd,
    output ex_pkg::fwd_sel_e      o_sel_a,
    output ex_pkg::fwd_sel_e      o_sel_b
);

    // A later stage matches when it writes a nonzero register equal to src
    function automatic logic fwd_hit(ex_pkg::fwd_src_t fwd, logic [`EX_REG_W-1:0] src);
        return fwd.reg_write && (fwd.dest_reg != '0) && (fwd.dest_reg == src);
    endfunction

    // MEM is the younger result, so it wins over WB
    function automatic ex_pkg::fwd_sel_e fwd_pick(logic [`EX_REG_W-1:0] src);
        ex_pkg::fwd_sel_e sel;
        if (fwd_hit(i_mem_fwd, src)) begin
            sel = ex_pkg::FWD_MEM;
        end else if (fwd_hit(i_wb_fwd, src)) begin
            sel = ex_pkg::FWD_WB;
        end else begin
            sel = ex_pkg::FWD_REG;
        end
        return sel;
    endfunction

    assign o_sel_a = fwd_pick(i_rs);
    assign o_sel_b = fwd_pick(i_rt);

endmodule

// File: design/stage_register.sv
`timescale 1ns/1ps

module stage_register #(
    parameter type payload_t = logic
) (
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_enable,
    input  payload_t  i_data,
    output payload_t  o_data
);

    // Holds its payload until enabled, clears to a bubble on reset
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_data <= '0;
        end else if (i_enable) begin
            o_data <= i_data;
        end
    end

endmodule

// File: design/step_controller.sv
`timescale 1ns/1ps

module step_controller (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_exec_mode,
    input  logic  i_step,
    input  logic  i_halt_seen,
    output logic  o_advance,
    output logic  o_halted
);

    typedef enum logic [1:0] {
        ST_RUN       = 2'd0,
        ST_STEP_WAIT = 2'd1,
        ST_HALTED    = 2'd2
    } state_e;

    state_e state;
    state_e state_next;

    // Comes out of reset waiting, first free-run cycle follows
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= ST_STEP_WAIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        if (state != ST_HALTED) begin
            if (i_halt_seen) begin
                state_next = ST_HALTED;
            end else if (i_exec_mode) begin
                state_next = ST_STEP_WAIT;
            end else begin
                state_next = ST_RUN;
            end
        end
    end

    // --------------------------------------------------
    // Advance enable
    // --------------------------------------------------
    always_comb begin
        case (state)
            ST_RUN, ST_STEP_WAIT: begin
                // Step mode follows the pulse, halt freezes both stages at once
                o_advance = !i_halt_seen && (i_exec_mode ? i_step : (state == ST_RUN));
            end
            default: o_advance = 1'b0;
        endcase
    end

    assign o_halted = (state == ST_HALTED);

endmodule

// File: include/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// --------------------------------------------------
// Execute stage widths
// --------------------------------------------------

// Data path and program counter width
`define EX_DATA_W 32

// Register file index width
`define EX_REG_W 5

// R-type function field width
`define EX_FUNCT_W 6

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ex_unit_tb -f verilog.f \
    --Mdir obj_dir -o ex_unit_sim

./obj_dir/ex_unit_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sim/ex_testdata.hex
// mode step flush | valid class alu_src reg_dst branch jump mem_rd mem_wr mem_to_reg wr halt
// pc_4 rd1 rd2 ext | funct rs rt rd sa | mem: wr dst data | wb: wr dst data | result store
0 0 0 1 0 0 1 0 0 0 0 0 1 0 104 5 3 0 20 1 2 3 0 0 0 0 0 0 0 8 3
0 0 0 1 0 0 1 0 0 0 0 0 1 0 108 3 3 0 22 1 2 3 0 0 0 0 0 0 0 0 3
0 0 0 1 0 0 1 0 0 0 0 0 1 0 10c f0f0 ff00 0 24 1 2 3 0 0 0 0 0 0 0 f000 ff00
0 0 0 1 0 0 1 0 0 0 0 0 1 0 110 f0f0 0f0f 0 25 1 2 3 0 0 0 0 0 0 0 ffff 0f0f
0 0 0 1 0 0 1 0 0 0 0 0 1 0 114 ff00 0ff0 0 26 1 2 3 0 0 0 0 0 0 0 f0f0 0ff0
0 0 0 1 0 0 1 0 0 0 0 0 1 0 118 ffff0000 ff00 0 27 1 2 3 0 0 0 0 0 0 0 ff ff00
0 0 0 1 0 0 1 0 0 0 0 0 1 0 11c ffffffff 1 0 2a 1 2 3 0 0 0 0 0 0 0 1 1
0 0 0 1 0 0 1 0 0 0 0 0 1 0 120 ffffffff 1 0 2b 1 2 3 0 0 0 0 0 0 0 0 1
0 0 0 1 0 0 1 0 0 0 0 0 1 0 124 7 1 0 0 1 2 3 4 0 0 0 0 0 0 10 1
0 0 0 1 0 0 1 0 0 0 0 0 1 0 128 7 80000000 0 2 1 2 3 4 0 0 0 0 0 0 8000000 80000000
0 0 0 1 0 0 1 0 0 0 0 0 1 0 12c 7 80000000 0 3 1 2 3 4 0 0 0 0 0 0 f8000000 80000000
0 0 0 1 1 1 0 1 0 0 0 0 1 0 130 10 9 fffffffc 0 1 2 3 0 0 0 0 0 0 0 c 9
0 0 0 1 3 1 0 0 0 0 0 0 1 0 134 1234 0 ff 0 1 2 3 0 0 0 0 0 0 0 34 0
0 0 0 1 4 1 0 0 0 0 0 0 1 0 138 1200 0 34 0 1 2 3 0 0 0 0 0 0 0 1234 0
0 0 0 1 5 1 0 0 0 0 0 0 1 0 13c ff 0 f 0 1 2 3 0 0 0 0 0 0 0 f0 0
0 0 0 1 6 1 0 0 0 0 0 0 1 0 140 5 0 7 0 1 2 3 0 0 0 0 0 0 0 1 0
0 0 0 1 7 1 0 0 0 0 0 0 1 0 144 0 0 1234 0 1 2 3 0 0 0 0 0 0 0 12340000 0
0 0 0 1 2 0 0 0 0 0 1 0 0 0 148 9 4 0 0 1 2 3 0 0 0 0 0 0 0 5 4
0 0 0 1 0 0 1 0 0 0 0 0 1 0 14c 5 6 0 20 1 2 3 0 1 1 100 1 2 20 120 20
0 0 0 1 0 0 1 0 0 0 0 0 1 0 150 5 6 0 20 1 2 3 0 1 2 30 1 2 40 35 30
0 0 0 1 0 0 1 0 0 0 0 0 1 0 154 7 1 0 20 0 2 3 0 1 0 999 0 2 55 8 1
0 0 1 1 0 0 1 0 0 0 0 0 1 0 158 1 1 0 20 1 2 3 0 0 0 0 0 0 0 0 0
0 0 0 1 0 0 1 0 0 0 0 0 1 0 15c 2 2 0 20 1 2 3 0 0 0 0 0 0 0 4 2
1 1 0 1 0 0 1 0 0 0 0 0 1 0 160 6 7 0 20 1 2 3 0 0 0 0 0 0 0 d 7
1 1 0 1 0 0 1 0 0 0 0 0 1 0 164 6 7 0 22 1 2 3 0 0 0 0 0 0 0 ffffffff 7
0 0 0 1 0 0 1 0 0 0 0 0 1 1 168 0 0 0 20 1 2 3 0 0 0 0 0 0 0 0 0
ff

// File: sim/ex_unit_tb.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_unit_tb;

    localparam int  REC_W       = 31;
    localparam int  MAX_RECS    = 32;
    localparam int  WAIT_LIMIT  = 20;
    localparam int  QUIET_CYCLES = 4;
    localparam time QUARTER     = 10ns;

    logic               i_clock;
    logic               i_reset;
    ex_pkg::id_ex_t     i_id_ex;
    ex_pkg::fwd_src_t   i_mem_fwd;
    ex_pkg::fwd_src_t   i_wb_fwd;
    logic               i_exec_mode;
    logic               i_step;
    logic               i_flush;
    ex_pkg::ex_mem_t    o_ex_mem;
    logic               o_advance;
    logic               o_halted;

    logic [31:0]        vec_mem [0:REC_W*MAX_RECS-1];
    ex_pkg::ex_mem_t    expected_q[$];
    int                 errors;

    // EX-side inputs of a record are applied while the next record is offered
    logic               pend_flush;
    ex_pkg::fwd_src_t   pend_mem_fwd;
    ex_pkg::fwd_src_t   pend_wb_fwd;

    tb_clock_gen u_clock_gen (
        .o_clock  (i_clock),
        .o_reset  (i_reset)
    );

    ex_unit_top DUT (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_id_ex      (i_id_ex),
        .i_mem_fwd    (i_mem_fwd),
        .i_wb_fwd     (i_wb_fwd),
        .i_exec_mode  (i_exec_mode),
        .i_step       (i_step),
        .i_flush      (i_flush),
        .o_ex_mem     (o_ex_mem),
        .o_advance    (o_advance),
        .o_halted     (o_halted)
    );

    // --------------------------------------------------
    // Error handling and compares
    // --------------------------------------------------
    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ex_mem(input ex_pkg::ex_mem_t got, input ex_pkg::ex_mem_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: o_ex_mem got %h expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_status(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // Record decoding
    // --------------------------------------------------
    function automatic ex_pkg::id_ex_t vector_to_id_ex(input int base);
        ex_pkg::id_ex_t v;
        v             = '0;
        v.valid       = vec_mem[base+3][0];
        v.alu_class   = ex_pkg::alu_class_e'(vec_mem[base+4][2:0]);
        v.alu_src     = vec_mem[base+5][0];
        v.reg_dst     = vec_mem[base+6][0];
        v.branch      = vec_mem[base+7][0];
        v.jump        = vec_mem[base+8][1:0];
        v.mem_read    = vec_mem[base+9][0];
        v.mem_write   = vec_mem[base+10][0];
        v.mem_to_reg  = vec_mem[base+11][0];
        v.reg_write   = vec_mem[base+12][0];
        v.halt        = vec_mem[base+13][0];
        v.pc_4        = vec_mem[base+14];
        v.read_data_1 = vec_mem[base+15];
        v.read_data_2 = vec_mem[base+16];
        v.extended    = vec_mem[base+17];
        v.funct       = vec_mem[base+18][`EX_FUNCT_W-1:0];
        v.rs          = vec_mem[base+19][`EX_REG_W-1:0];
        v.rt          = vec_mem[base+20][`EX_REG_W-1:0];
        v.rd          = vec_mem[base+21][`EX_REG_W-1:0];
        v.sa          = vec_mem[base+22][`EX_REG_W-1:0];
        return v;
    endfunction

    function automatic ex_pkg::fwd_src_t vector_to_fwd(input int idx);
        ex_pkg::fwd_src_t f;
        f.reg_write = vec_mem[idx][0];
        f.dest_reg  = vec_mem[idx+1][`EX_REG_W-1:0];
        f.data      = vec_mem[idx+2];
        return f;
    endfunction

    // Expected EX/MEM item from the pass-through and address rules
    function automatic ex_pkg::ex_mem_t make_expected(
        input ex_pkg::id_ex_t v,
        input logic [`EX_DATA_W-1:0] result,
        input logic [`EX_DATA_W-1:0] store
    );
        ex_pkg::ex_mem_t e;
        e            = '0;
        e.valid      = 1'b1;
        e.branch     = v.branch;
        e.jump       = v.jump;
        e.mem_read   = v.mem_read;
        e.mem_write  = v.mem_write;
        e.mem_to_reg = v.mem_to_reg;
        e.reg_write  = v.reg_write;
        e.halt       = v.halt;
        e.pc_4       = v.pc_4;
        e.pc_branch  = v.pc_4 + {v.extended[`EX_DATA_W-3:0], 2'b00};
        e.alu_result = result;
        e.store_data = store;
        e.funct      = v.funct;
        e.dest_reg   = v.reg_dst ? v.rd : v.rt;
        e.zero       = (result == '0);
        return e;
    endfunction

    // --------------------------------------------------
    // Driving
    // --------------------------------------------------
    task automatic wait_advance(input string what);
        logic taken;
        taken = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !taken; i++) begin
            #(QUARTER);
            taken = o_advance;
            @(negedge i_clock);
        end
        if (!taken) begin
            abort_run($sformatf("timeout at %0t: %s was never taken", $time, what));
        end
    endtask

    task automatic run_record(input int base);
        ex_pkg::id_ex_t v;
        v           = vector_to_id_ex(base);
        i_id_ex     = v;
        i_exec_mode = vec_mem[base][0];
        i_step      = 1'b0;
        i_flush     = pend_flush;
        i_mem_fwd   = pend_mem_fwd;
        i_wb_fwd    = pend_wb_fwd;
        if (i_exec_mode) begin
            // Nothing may move until the step pulse
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge i_clock);
                #(QUARTER);
                check_status(o_ex_mem.valid, 1'b0, "o_ex_mem.valid");
                check_status(o_advance, 1'b0, "o_advance");
            end
            @(negedge i_clock);
            i_step = vec_mem[base+1][0];
        end
        if (v.valid && !vec_mem[base+2][0]) begin
            expected_q.push_back(make_expected(v, vec_mem[base+29], vec_mem[base+30]));
        end
        pend_flush   = vec_mem[base+2][0];
        pend_mem_fwd = vector_to_fwd(base+23);
        pend_wb_fwd  = vector_to_fwd(base+26);
        wait_advance($sformatf("record at word %0d", base));
    endtask

    // Every valid output is matched against the oldest expected item
    always @(negedge i_clock) begin
        if (o_ex_mem.valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("unexpected valid output at %0t", $time));
            end else begin
                check_ex_mem(o_ex_mem, expected_q.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic done;
        int   rec;
        errors       = 0;
        i_id_ex      = '0;
        i_mem_fwd    = '0;
        i_wb_fwd     = '0;
        i_exec_mode  = 1'b0;
        i_step       = 1'b0;
        i_flush      = 1'b0;
        pend_flush   = 1'b0;
        pend_mem_fwd = '0;
        pend_wb_fwd  = '0;
        $readmemh("sim/ex_testdata.hex", vec_mem);

        // Reset values, checked until just after release
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            @(negedge i_clock);
            #(QUARTER);
            check_status(o_ex_mem.valid, 1'b0, "o_ex_mem.valid");
            check_status(o_advance, 1'b0, "o_advance");
            check_status(o_halted, 1'b0, "o_halted");
            done = !i_reset;
        end
        if (!done) begin
            abort_run("reset was never released");
        end
        @(negedge i_clock);

        rec = 0;
        while (rec < MAX_RECS && vec_mem[rec*REC_W] != 32'hff) begin
            run_record(rec * REC_W);
            rec++;
        end

        // Valid instruction queued behind the halt that must never come out
        i_id_ex     = vector_to_id_ex(0);
        i_exec_mode = 1'b0;
        i_step      = 1'b0;
        i_flush     = pend_flush;
        i_mem_fwd   = pend_mem_fwd;
        i_wb_fwd    = pend_wb_fwd;
        wait_advance("instruction behind the halt");

        for (int i = 0; i < WAIT_LIMIT && expected_q.size() != 0; i++) begin
            @(negedge i_clock);
        end
        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never appeared", expected_q.size()));
        end

        // Halt must freeze the pipeline for good
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            @(negedge i_clock);
            #(QUARTER);
            done = o_halted;
        end
        if (!done) begin
            abort_run("the halt instruction never raised o_halted");
        end
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(negedge i_clock);
            #(QUARTER);
            check_status(o_advance, 1'b0, "o_advance");
            check_status(o_ex_mem.valid, 1'b0, "o_ex_mem.valid");
            check_status(o_halted, 1'b1, "o_halted");
        end

        if (errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "errors were recorded");
        end
    end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic  o_clock,
    output logic  o_reset
);

    localparam time HALF_PERIOD = 20ns;
    localparam int  RESET_CYCLES = 8;

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        @(negedge o_clock);
        o_reset = 1'b0;
    end

endmodule

// File: verilog.f
+incdir+include
design/ex_pkg.sv
design/alu_control.sv
design/alu.sv
design/forwarding_unit.sv
design/stage_register.sv
design/step_controller.sv
design/execute_stage.sv
design/ex_unit_top.sv
sim/tb_clock_gen.sv
sim/ex_unit_tb.sv
